//--- dispatch_pkg.sv
package dispatch_pkg;

    // datapath widths
    localparam int WORD_W = 32;
    localparam int FU_W   = 3;

    // rob size, the top level may override it
    localparam int ROB_DEPTH = 32;
    localparam int ROB_AW    = $clog2(ROB_DEPTH);

    // reservation station depths (entries per station)
    localparam int ALU_DEPTH = 4;   // each of alu0 and alu1
    localparam int MU_DEPTH  = 3;
    localparam int MDU_DEPTH = 2;

    // bit positions inside the one-hot unit class
    localparam int FU_ALU = 0;
    localparam int FU_MU  = 1;
    localparam int FU_MDU = 2;

    // operand or rob result value
    typedef logic [WORD_W-1:0] word_t;

    // rob entry number, also the producer tag of an operand
    typedef logic [ROB_AW-1:0] rob_idx_t;

    // one-hot class, exceptions arrive from decode already as alu
    typedef logic [FU_W-1:0] fu_t;

endpackage

//--- slot_classify.sv
`timescale 1ns/1ps

module slot_classify (
    input  logic              clk,
    input  logic              resetn,
    input  logic              flush,
    input  logic              valid0,
    input  logic              valid1,
    input  dispatch_pkg::fu_t fu0,
    input  dispatch_pkg::fu_t fu1,
    input  logic              dispatch_busy,
    input  logic              sent0,
    input  logic              sent1,
    output logic              live0,
    output logic              live1,
    output dispatch_pkg::fu_t fu_live0,
    output dispatch_pkg::fu_t fu_live1
);

    // pending bits, cleared once a slot of a stalled pair is placed
    logic pending0;
    logic pending1;

    // rename holds the pair while busy, so a placed slot must be hidden
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending0 <= 1'b1;
            pending1 <= 1'b1;
        end else if (flush || !dispatch_busy) begin
            pending0 <= 1'b1;   // fresh pair next cycle
            pending1 <= 1'b1;
        end else begin
            if (sent0) begin
                pending0 <= 1'b0;
            end
            if (sent1) begin
                pending1 <= 1'b0;
            end
        end
    end

    assign live0 = valid0 & pending0;
    assign live1 = valid1 & pending1;

    // class request only for slots still waiting for a station
    assign fu_live0 = live0 ? fu0 : '0;
    assign fu_live1 = live1 ? fu1 : '0;

endmodule

//--- station_alloc.sv
`timescale 1ns/1ps

module station_alloc #(
    parameter int ALU_DEPTH = dispatch_pkg::ALU_DEPTH,
    parameter int MU_DEPTH  = dispatch_pkg::MU_DEPTH,
    parameter int MDU_DEPTH = dispatch_pkg::MDU_DEPTH
) (
    input  dispatch_pkg::fu_t     fu_live0,
    input  dispatch_pkg::fu_t     fu_live1,
    input  logic                  live0,
    input  logic                  live1,
    input  logic [ALU_DEPTH-1:0]  alu0_occupied,
    input  logic [ALU_DEPTH-1:0]  alu1_occupied,
    input  logic [MU_DEPTH-1:0]   mu_occupied,
    input  logic [MDU_DEPTH-1:0]  mdu_occupied,
    output logic [ALU_DEPTH-1:0]  wen_alu0_0,
    output logic [ALU_DEPTH-1:0]  wen_alu0_1,
    output logic [ALU_DEPTH-1:0]  wen_alu1_0,
    output logic [ALU_DEPTH-1:0]  wen_alu1_1,
    output logic [MU_DEPTH-1:0]   wen_mu_0,
    output logic [MU_DEPTH-1:0]   wen_mu_1,
    output logic [MDU_DEPTH-1:0]  wen_mdu_0,
    output logic [MDU_DEPTH-1:0]  wen_mdu_1,
    output logic                  dispatch_busy,
    output logic                  sent0,
    output logic                  sent1
);

    import dispatch_pkg::*;

    localparam int MAX_AM = (ALU_DEPTH > MU_DEPTH) ? ALU_DEPTH : MU_DEPTH;
    localparam int MAX_D  = (MAX_AM > MDU_DEPTH) ? MAX_AM : MDU_DEPTH;
    localparam int CNT_W  = $clog2(ALU_DEPTH + 1);

    logic [MAX_D-1:0]     alu0_pick, alu1_pick, mu_pick, mdu_pick;
    logic [ALU_DEPTH-1:0] alu0_free, alu1_free;
    logic [MU_DEPTH-1:0]  mu_free;
    logic [MDU_DEPTH-1:0] mdu_free;
    logic [CNT_W-1:0]     alu0_used, alu1_used;
    logic alu0_room, alu1_room, mu_room, mdu_room;
    logic alu_a, alu_b, both_alu;
    logic single_to0, single_to1;
    logic s0_alu0, s0_alu1, s0_mu, s0_mdu;
    logic s1_alu0, s1_alu1, s1_mu, s1_mdu;

    // lowest free entry below depth, one-hot, zero when station is full
    function automatic logic [MAX_D-1:0] first_free(input logic [MAX_D-1:0] occ,
                                                    input int depth);
        logic [MAX_D-1:0] pick;
        logic             found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < MAX_D; i++) begin
            if (!found && i < depth && !occ[i]) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
        return pick;
    endfunction

    assign alu0_pick = first_free(MAX_D'(alu0_occupied), ALU_DEPTH);
    assign alu1_pick = first_free(MAX_D'(alu1_occupied), ALU_DEPTH);
    assign mu_pick   = first_free(MAX_D'(mu_occupied), MU_DEPTH);
    assign mdu_pick  = first_free(MAX_D'(mdu_occupied), MDU_DEPTH);

    assign alu0_free = alu0_pick[ALU_DEPTH-1:0];
    assign alu1_free = alu1_pick[ALU_DEPTH-1:0];
    assign mu_free   = mu_pick[MU_DEPTH-1:0];
    assign mdu_free  = mdu_pick[MDU_DEPTH-1:0];

    assign alu0_room = |alu0_free;
    assign alu1_room = |alu1_free;
    assign mu_room   = |mu_free;
    assign mdu_room  = |mdu_free;

    // occupancy counts for balancing the two alu stations
    always_comb begin
        alu0_used = '0;
        alu1_used = '0;
        for (int i = 0; i < ALU_DEPTH; i++) begin
            alu0_used = alu0_used + CNT_W'(alu0_occupied[i]);
            alu1_used = alu1_used + CNT_W'(alu1_occupied[i]);
        end
    end

    assign alu_a    = fu_live0[FU_ALU];
    assign alu_b    = fu_live1[FU_ALU];
    assign both_alu = alu_a & alu_b;

    // lone alu slot, less loaded station wins, tie to alu0, spill if full
    assign single_to1 = alu1_room & ((alu1_used < alu0_used) | ~alu0_room);
    assign single_to0 = alu0_room & ~single_to1;

    // alu pair takes both stations, or slot 0 takes the one with room
    assign s0_alu0 = alu_a & (both_alu ? alu0_room : single_to0);
    assign s0_alu1 = alu_a & (both_alu ? (alu1_room & ~alu0_room) : single_to1);
    assign s1_alu0 = alu_b & ~both_alu & single_to0;
    assign s1_alu1 = alu_b & (both_alu ? (alu0_room & alu1_room) : single_to1);

    // one write port per mu/mdu station, slot 0 first
    assign s0_mu  = fu_live0[FU_MU] & mu_room;
    assign s1_mu  = fu_live1[FU_MU] & ~fu_live0[FU_MU] & mu_room;
    assign s0_mdu = fu_live0[FU_MDU] & mdu_room;
    assign s1_mdu = fu_live1[FU_MDU] & ~fu_live0[FU_MDU] & mdu_room;

    assign wen_alu0_0 = {ALU_DEPTH{s0_alu0}} & alu0_free;
    assign wen_alu0_1 = {ALU_DEPTH{s1_alu0}} & alu0_free;
    assign wen_alu1_0 = {ALU_DEPTH{s0_alu1}} & alu1_free;
    assign wen_alu1_1 = {ALU_DEPTH{s1_alu1}} & alu1_free;
    assign wen_mu_0   = {MU_DEPTH{s0_mu}} & mu_free;
    assign wen_mu_1   = {MU_DEPTH{s1_mu}} & mu_free;
    assign wen_mdu_0  = {MDU_DEPTH{s0_mdu}} & mdu_free;
    assign wen_mdu_1  = {MDU_DEPTH{s1_mdu}} & mdu_free;

    assign sent0 = s0_alu0 | s0_alu1 | s0_mu | s0_mdu;
    assign sent1 = s1_alu0 | s1_alu1 | s1_mu | s1_mdu;

    // stall whenever a slot that still waits found no entry
    assign dispatch_busy = (live0 & ~sent0) | (live1 & ~sent1);

endmodule

//--- operand_merge.sv
`timescale 1ns/1ps

module operand_merge (
    input  logic                rs_ready0,
    input  logic                rt_ready0,
    input  logic                rs_ready1,
    input  logic                rt_ready1,
    input  dispatch_pkg::word_t rs_val0,
    input  dispatch_pkg::word_t rt_val0,
    input  dispatch_pkg::word_t rs_val1,
    input  dispatch_pkg::word_t rt_val1,
    input  dispatch_pkg::word_t rob_rdata0,   // rs of slot 0
    input  dispatch_pkg::word_t rob_rdata1,   // rt of slot 0
    input  dispatch_pkg::word_t rob_rdata2,   // rs of slot 1
    input  dispatch_pkg::word_t rob_rdata3,   // rt of slot 1
    input  logic                rob_ready0,
    input  logic                rob_ready1,
    input  logic                rob_ready2,
    input  logic                rob_ready3,
    output dispatch_pkg::word_t op_rs_val0,
    output dispatch_pkg::word_t op_rt_val0,
    output dispatch_pkg::word_t op_rs_val1,
    output dispatch_pkg::word_t op_rt_val1,
    output logic                op_rs_ready0,
    output logic                op_rt_ready0,
    output logic                op_rs_ready1,
    output logic                op_rt_ready1
);

    // value captured at rename wins, else whatever the rob holds now
    assign op_rs_val0 = rs_ready0 ? rs_val0 : rob_rdata0;
    assign op_rt_val0 = rt_ready0 ? rt_val0 : rob_rdata1;
    assign op_rs_val1 = rs_ready1 ? rs_val1 : rob_rdata2;
    assign op_rt_val1 = rt_ready1 ? rt_val1 : rob_rdata3;

    // operand may have completed between rename and dispatch
    assign op_rs_ready0 = rs_ready0 | rob_ready0;
    assign op_rt_ready0 = rt_ready0 | rob_ready1;
    assign op_rs_ready1 = rs_ready1 | rob_ready2;
    assign op_rt_ready1 = rt_ready1 | rob_ready3;

endmodule

//--- dispatch_top.sv
`timescale 1ns/1ps

module dispatch_top #(
    parameter int ROB_DEPTH = dispatch_pkg::ROB_DEPTH,
    parameter int ALU_DEPTH = dispatch_pkg::ALU_DEPTH,
    parameter int MU_DEPTH  = dispatch_pkg::MU_DEPTH,
    parameter int MDU_DEPTH = dispatch_pkg::MDU_DEPTH
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   flush,           // from commit
    input  logic                   valid0,
    input  logic                   valid1,
    input  dispatch_pkg::fu_t      fu0,
    input  dispatch_pkg::fu_t      fu1,
    input  dispatch_pkg::rob_idx_t rs_num0,
    input  dispatch_pkg::rob_idx_t rt_num0,
    input  dispatch_pkg::rob_idx_t rs_num1,
    input  dispatch_pkg::rob_idx_t rt_num1,
    input  logic                   rs_ready0,
    input  logic                   rt_ready0,
    input  logic                   rs_ready1,
    input  logic                   rt_ready1,
    input  dispatch_pkg::word_t    rs_val0,
    input  dispatch_pkg::word_t    rt_val0,
    input  dispatch_pkg::word_t    rs_val1,
    input  dispatch_pkg::word_t    rt_val1,
    output dispatch_pkg::rob_idx_t rob_raddr0,
    output dispatch_pkg::rob_idx_t rob_raddr1,
    output dispatch_pkg::rob_idx_t rob_raddr2,
    output dispatch_pkg::rob_idx_t rob_raddr3,
    input  dispatch_pkg::word_t    rob_rdata0,
    input  dispatch_pkg::word_t    rob_rdata1,
    input  dispatch_pkg::word_t    rob_rdata2,
    input  dispatch_pkg::word_t    rob_rdata3,
    input  logic                   rob_ready0,
    input  logic                   rob_ready1,
    input  logic                   rob_ready2,
    input  logic                   rob_ready3,
    input  logic [ALU_DEPTH-1:0]   alu0_occupied,   // 1 = entry taken
    input  logic [ALU_DEPTH-1:0]   alu1_occupied,
    input  logic [MU_DEPTH-1:0]    mu_occupied,
    input  logic [MDU_DEPTH-1:0]   mdu_occupied,
    output logic [ALU_DEPTH-1:0]   wen_alu0_0,
    output logic [ALU_DEPTH-1:0]   wen_alu0_1,
    output logic [ALU_DEPTH-1:0]   wen_alu1_0,
    output logic [ALU_DEPTH-1:0]   wen_alu1_1,
    output logic [MU_DEPTH-1:0]    wen_mu_0,
    output logic [MU_DEPTH-1:0]    wen_mu_1,
    output logic [MDU_DEPTH-1:0]   wen_mdu_0,
    output logic [MDU_DEPTH-1:0]   wen_mdu_1,
    output logic                   dispatch_busy,   // back to rename
    output dispatch_pkg::word_t    op_rs_val0,
    output dispatch_pkg::word_t    op_rt_val0,
    output dispatch_pkg::word_t    op_rs_val1,
    output dispatch_pkg::word_t    op_rt_val1,
    output logic                   op_rs_ready0,
    output logic                   op_rt_ready0,
    output logic                   op_rs_ready1,
    output logic                   op_rt_ready1
);

    import dispatch_pkg::*;

    fu_t  fu_live0, fu_live1;
    logic live0, live1;
    logic sent0, sent1;

    // the rob tag type comes from the package, its depth must agree
    if ($bits(rob_idx_t) != $clog2(ROB_DEPTH)) begin : g_rob_width
        $error("ROB_DEPTH %0d does not match rob_idx_t width", ROB_DEPTH);
    end

    // rename tags index the rob directly
    assign rob_raddr0 = rs_num0;
    assign rob_raddr1 = rt_num0;
    assign rob_raddr2 = rs_num1;
    assign rob_raddr3 = rt_num1;

    slot_classify u_classify (
        .clk           (clk),
        .resetn        (resetn),
        .flush         (flush),
        .valid0        (valid0),
        .valid1        (valid1),
        .fu0           (fu0),
        .fu1           (fu1),
        .dispatch_busy (dispatch_busy),
        .sent0         (sent0),
        .sent1         (sent1),
        .live0         (live0),
        .live1         (live1),
        .fu_live0      (fu_live0),
        .fu_live1      (fu_live1)
    );

    station_alloc #(
        .ALU_DEPTH (ALU_DEPTH),
        .MU_DEPTH  (MU_DEPTH),
        .MDU_DEPTH (MDU_DEPTH)
    ) u_alloc (
        .fu_live0      (fu_live0),
        .fu_live1      (fu_live1),
        .live0         (live0),
        .live1         (live1),
        .alu0_occupied (alu0_occupied),
        .alu1_occupied (alu1_occupied),
        .mu_occupied   (mu_occupied),
        .mdu_occupied  (mdu_occupied),
        .wen_alu0_0    (wen_alu0_0),
        .wen_alu0_1    (wen_alu0_1),
        .wen_alu1_0    (wen_alu1_0),
        .wen_alu1_1    (wen_alu1_1),
        .wen_mu_0      (wen_mu_0),
        .wen_mu_1      (wen_mu_1),
        .wen_mdu_0     (wen_mdu_0),
        .wen_mdu_1     (wen_mdu_1),
        .dispatch_busy (dispatch_busy),
        .sent0         (sent0),
        .sent1         (sent1)
    );

    operand_merge u_merge (
        .rs_ready0    (rs_ready0),
        .rt_ready0    (rt_ready0),
        .rs_ready1    (rs_ready1),
        .rt_ready1    (rt_ready1),
        .rs_val0      (rs_val0),
        .rt_val0      (rt_val0),
        .rs_val1      (rs_val1),
        .rt_val1      (rt_val1),
        .rob_rdata0   (rob_rdata0),
        .rob_rdata1   (rob_rdata1),
        .rob_rdata2   (rob_rdata2),
        .rob_rdata3   (rob_rdata3),
        .rob_ready0   (rob_ready0),
        .rob_ready1   (rob_ready1),
        .rob_ready2   (rob_ready2),
        .rob_ready3   (rob_ready3),
        .op_rs_val0   (op_rs_val0),
        .op_rt_val0   (op_rt_val0),
        .op_rs_val1   (op_rs_val1),
        .op_rt_val1   (op_rt_val1),
        .op_rs_ready0 (op_rs_ready0),
        .op_rt_ready0 (op_rt_ready0),
        .op_rs_ready1 (op_rs_ready1),
        .op_rt_ready1 (op_rt_ready1)
    );

endmodule

//--- dispatch_chk.sv
`timescale 1ns/1ps

module dispatch_chk #(
    parameter int ALU_DEPTH = dispatch_pkg::ALU_DEPTH,
    parameter int MU_DEPTH  = dispatch_pkg::MU_DEPTH,
    parameter int MDU_DEPTH = dispatch_pkg::MDU_DEPTH
) (
    input logic                 clk,
    input logic                 resetn,
    input logic [ALU_DEPTH-1:0] alu0_occupied,
    input logic [ALU_DEPTH-1:0] alu1_occupied,
    input logic [MU_DEPTH-1:0]  mu_occupied,
    input logic [MDU_DEPTH-1:0] mdu_occupied,
    input logic [ALU_DEPTH-1:0] wen_alu0_0,
    input logic [ALU_DEPTH-1:0] wen_alu0_1,
    input logic [ALU_DEPTH-1:0] wen_alu1_0,
    input logic [ALU_DEPTH-1:0] wen_alu1_1,
    input logic [MU_DEPTH-1:0]  wen_mu_0,
    input logic [MU_DEPTH-1:0]  wen_mu_1,
    input logic [MDU_DEPTH-1:0] wen_mdu_0,
    input logic [MDU_DEPTH-1:0] wen_mdu_1
);

    int onehot_fails   = 0;
    int occupied_fails = 0;
    int station_fails  = 0;

    logic [3:0] slot0_hits;   // alu0 alu1 mu mdu
    logic [3:0] slot1_hits;

    assign slot0_hits = {|wen_alu0_0, |wen_alu1_0, |wen_mu_0, |wen_mdu_0};
    assign slot1_hits = {|wen_alu0_1, |wen_alu1_1, |wen_mu_1, |wen_mdu_1};

    wen_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(wen_alu0_0) && $onehot0(wen_alu0_1) && $onehot0(wen_alu1_0) &&
        $onehot0(wen_alu1_1) && $onehot0(wen_mu_0) && $onehot0(wen_mu_1) &&
        $onehot0(wen_mdu_0) && $onehot0(wen_mdu_1))
        else begin
            $error("write enable with more than one entry set");
            onehot_fails++;
        end

    // a new entry may only land where the station has a hole
    wen_free: assert property (@(posedge clk) disable iff (!resetn)
        ((wen_alu0_0 | wen_alu0_1) & alu0_occupied) == '0 &&
        ((wen_alu1_0 | wen_alu1_1) & alu1_occupied) == '0 &&
        ((wen_mu_0 | wen_mu_1) & mu_occupied) == '0 &&
        ((wen_mdu_0 | wen_mdu_1) & mdu_occupied) == '0)
        else begin
            $error("write enable points at an occupied entry");
            occupied_fails++;
        end

    one_station: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(slot0_hits) && $onehot0(slot1_hits))
        else begin
            $error("slot written into two stations in one cycle");
            station_fails++;
        end

endmodule

bind dispatch_top dispatch_chk #(
    .ALU_DEPTH (ALU_DEPTH),
    .MU_DEPTH  (MU_DEPTH),
    .MDU_DEPTH (MDU_DEPTH)
) u_chk (.*);

//--- tb_dispatch.sv
`timescale 1ns/1ps

module tb_dispatch;

    import dispatch_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int FIELDS     = 25;   // words per trace record
    localparam int MAX_REC    = 64;

    logic                 clk;
    logic                 resetn;
    logic                 flush;
    logic                 valid0, valid1;
    fu_t                  fu0, fu1;
    rob_idx_t             rs_num0, rt_num0, rs_num1, rt_num1;
    rob_idx_t             rob_raddr0, rob_raddr1, rob_raddr2, rob_raddr3;
    logic                 rs_ready0, rt_ready0, rs_ready1, rt_ready1;
    word_t                rs_val0, rt_val0, rs_val1, rt_val1;
    word_t                rob_rdata0, rob_rdata1, rob_rdata2, rob_rdata3;
    logic                 rob_ready0, rob_ready1, rob_ready2, rob_ready3;
    logic [ALU_DEPTH-1:0] alu0_occupied, alu1_occupied;
    logic [MU_DEPTH-1:0]  mu_occupied;
    logic [MDU_DEPTH-1:0] mdu_occupied;
    logic [ALU_DEPTH-1:0] wen_alu0_0, wen_alu0_1, wen_alu1_0, wen_alu1_1;
    logic [MU_DEPTH-1:0]  wen_mu_0, wen_mu_1;
    logic [MDU_DEPTH-1:0] wen_mdu_0, wen_mdu_1;
    logic                 dispatch_busy;
    word_t                op_rs_val0, op_rt_val0, op_rs_val1, op_rt_val1;
    logic                 op_rs_ready0, op_rt_ready0, op_rs_ready1, op_rt_ready1;

    logic [31:0] trace_mem [0:FIELDS*MAX_REC-1];
    int          n_rec;
    bit          loaded;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          assert_fails;

    dispatch_top uut (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    // watchdog sized once the trace length is known
    initial begin
        wait (loaded);
        #((n_rec + 20) * CLK_PERIOD);
        $display("timeout: %0d trace records did not complete in time", n_rec);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic apply_record(input int r);
        int          b;
        logic [31:0] occ;
        logic [31:0] rdy;
        logic [31:0] nums;
        b    = r * FIELDS;
        occ  = trace_mem[b+6];
        rdy  = trace_mem[b+7];
        nums = trace_mem[b+8];
        flush  = trace_mem[b+1][0];
        valid0 = trace_mem[b+2][0];
        valid1 = trace_mem[b+3][0];
        fu0    = trace_mem[b+4][FU_W-1:0];
        fu1    = trace_mem[b+5][FU_W-1:0];
        alu0_occupied = occ[12 +: ALU_DEPTH];
        alu1_occupied = occ[8 +: ALU_DEPTH];
        mu_occupied   = occ[4 +: MU_DEPTH];
        mdu_occupied  = occ[0 +: MDU_DEPTH];
        {rs_ready0, rt_ready0, rs_ready1, rt_ready1}     = rdy[7:4];
        {rob_ready0, rob_ready1, rob_ready2, rob_ready3} = rdy[3:0];
        rs_num0 = nums[24 +: ROB_AW];   // one byte per tag
        rt_num0 = nums[16 +: ROB_AW];
        rs_num1 = nums[8 +: ROB_AW];
        rt_num1 = nums[0 +: ROB_AW];
        rs_val0    = trace_mem[b+9];
        rt_val0    = trace_mem[b+10];
        rs_val1    = trace_mem[b+11];
        rt_val1    = trace_mem[b+12];
        rob_rdata0 = trace_mem[b+13];
        rob_rdata1 = trace_mem[b+14];
        rob_rdata2 = trace_mem[b+15];
        rob_rdata3 = trace_mem[b+16];
    endtask

    task automatic check_record(input int r);
        int          b;
        logic [3:0]  act_wen [8];
        word_t       act_op [4];
        logic        act_rdy [4];
        rob_idx_t    act_raddr [4];
        string       wen_name [8];
        string       op_name [4];
        string       rdy_name [4];
        string       raddr_name [4];
        b = r * FIELDS;
        wen_name = '{"wen_alu0_0", "wen_alu0_1", "wen_alu1_0", "wen_alu1_1",
                     "wen_mu_0", "wen_mu_1", "wen_mdu_0", "wen_mdu_1"};
        op_name  = '{"op_rs_val0", "op_rt_val0", "op_rs_val1", "op_rt_val1"};
        rdy_name = '{"op_rs_ready0", "op_rt_ready0", "op_rs_ready1", "op_rt_ready1"};
        raddr_name = '{"rob_raddr0", "rob_raddr1", "rob_raddr2", "rob_raddr3"};
        act_wen  = '{4'(wen_alu0_0), 4'(wen_alu0_1), 4'(wen_alu1_0), 4'(wen_alu1_1),
                     4'(wen_mu_0), 4'(wen_mu_1), 4'(wen_mdu_0), 4'(wen_mdu_1)};
        act_op   = '{op_rs_val0, op_rt_val0, op_rs_val1, op_rt_val1};
        act_rdy  = '{op_rs_ready0, op_rt_ready0, op_rs_ready1, op_rt_ready1};
        act_raddr = '{rob_raddr0, rob_raddr1, rob_raddr2, rob_raddr3};
        for (int i = 0; i < 8; i++) begin
            if (act_wen[i] !== trace_mem[b+17][28-4*i +: 4]) begin
                $display("MISMATCH %s: expected %h, got %h",
                         wen_name[i], trace_mem[b+17][28-4*i +: 4], act_wen[i]);
                test_errors++;
            end
        end
        if (dispatch_busy !== trace_mem[b+18][0]) begin
            $display("MISMATCH dispatch_busy: expected %h, got %h",
                     trace_mem[b+18][0], dispatch_busy);
            test_errors++;
        end
        for (int i = 0; i < 4; i++) begin
            if (act_rdy[i] !== trace_mem[b+19][3-i]) begin
                $display("MISMATCH %s: expected %h, got %h",
                         rdy_name[i], trace_mem[b+19][3-i], act_rdy[i]);
                test_errors++;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (act_op[i] !== trace_mem[b+20+i]) begin
                $display("MISMATCH %s: expected %h, got %h",
                         op_name[i], trace_mem[b+20+i], act_op[i]);
                test_errors++;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (act_raddr[i] !== trace_mem[b+24][24-8*i +: ROB_AW]) begin
                $display("MISMATCH %s: expected %h, got %h",
                         raddr_name[i], trace_mem[b+24][24-8*i +: ROB_AW], act_raddr[i]);
                test_errors++;
            end
        end
    endtask

    task automatic close_test(input logic [31:0] id);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok", id);
        end else begin
            tests_failed++;
            $display("test %0d: FAIL with %0d mismatches", id, test_errors);
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    initial begin
        clk    = 1'b0;
        resetn = 1'b0;
        {flush, valid0, valid1, fu0, fu1} = '0;
        {rs_num0, rt_num0, rs_num1, rt_num1} = '0;
        {rs_ready0, rt_ready0, rs_ready1, rt_ready1} = '0;
        {rob_ready0, rob_ready1, rob_ready2, rob_ready3} = '0;
        {rs_val0, rt_val0, rs_val1, rt_val1} = '0;
        {rob_rdata0, rob_rdata1, rob_rdata2, rob_rdata3} = '0;
        {alu0_occupied, alu1_occupied, mu_occupied, mdu_occupied} = '0;
        {errors, test_errors, tests_run, tests_failed} = '0;
        for (int i = 0; i < FIELDS * MAX_REC; i++) begin
            trace_mem[i] = '1;   // end marker where the file stops
        end
        $readmemh("dispatch_trace.txt", trace_mem);
        n_rec = 0;
        while (n_rec < MAX_REC && trace_mem[n_rec*FIELDS] !== '1) begin
            n_rec++;
        end
        loaded = 1'b1;
        if (n_rec == 0) begin
            $display("no trace records could be read from dispatch_trace.txt");
        end
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int r = 0; r < n_rec; r++) begin
            apply_record(r);
            #(CLK_PERIOD - 2);   // just before the next edge
            check_record(r);
            if (r == n_rec - 1 || trace_mem[(r+1)*FIELDS] != trace_mem[r*FIELDS]) begin
                close_test(trace_mem[r*FIELDS]);
            end
            @(posedge clk);
            #1;
        end
        assert_fails = uut.u_chk.onehot_fails + uut.u_chk.occupied_fails +
                       uut.u_chk.station_fails;
        if (assert_fails != 0) begin
            $display("checker assertions failed %0d times", assert_fails);
        end
        $display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0 && n_rec > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- dispatch_trace.txt
// one record per cycle, hex: test flush valid0 valid1 fu0 fu1 occ rdy nums rs0 rt0 rs1 rt1
//   rob0 rob1 rob2 rob3, then expected: wen busy op_rdy op_rs0 op_rt0 op_rs1 op_rt1 raddr
// occ nibbles alu0 alu1 mu mdu, rdy rename/rob nibbles, wen nibbles alu0_0 .. mdu_1
// reset and idle
01 0 0 0 0 0 0000 f0 00010203 11 12 13 14 91 92 93 94 00000000 0 f 11 12 13 14 00010203
01 0 0 0 1 4 0000 f0 1f1e1d1c 11 12 13 14 91 92 93 94 00000000 0 f 11 12 13 14 1f1e1d1c
// alu balancing
02 0 1 0 1 0 0000 f0 00010203 11 12 13 14 91 92 93 94 10000000 0 f 11 12 13 14 00010203
02 0 1 0 1 0 3100 f0 00010203 11 12 13 14 91 92 93 94 00200000 0 f 11 12 13 14 00010203
02 0 0 1 0 1 1500 f0 00010203 11 12 13 14 91 92 93 94 02000000 0 f 11 12 13 14 00010203
02 0 1 0 1 0 8100 f0 00010203 11 12 13 14 91 92 93 94 10000000 0 f 11 12 13 14 00010203
02 0 1 1 1 1 0000 f0 00010203 11 12 13 14 91 92 93 94 10010000 0 f 11 12 13 14 00010203
02 0 1 1 1 1 5300 f0 00010203 11 12 13 14 91 92 93 94 20040000 0 f 11 12 13 14 00010203
// mu pair, then mdu pair
03 0 1 1 2 2 0000 f0 00010203 11 12 13 14 91 92 93 94 00001000 1 f 11 12 13 14 00010203
03 0 1 1 2 2 0000 f0 00010203 11 12 13 14 91 92 93 94 00000100 0 f 11 12 13 14 00010203
03 0 1 1 4 4 0001 f0 00010203 11 12 13 14 91 92 93 94 00000020 1 f 11 12 13 14 00010203
03 0 1 1 4 4 0001 f0 00010203 11 12 13 14 91 92 93 94 00000002 0 f 11 12 13 14 00010203
// full mdu station, then full alu0 with an alu pair
04 0 1 1 4 1 0003 f0 00010203 11 12 13 14 91 92 93 94 01000000 1 f 11 12 13 14 00010203
04 0 1 1 4 1 0003 f0 00010203 11 12 13 14 91 92 93 94 00000000 1 f 11 12 13 14 00010203
04 0 1 1 4 1 0002 f0 00010203 11 12 13 14 91 92 93 94 00000010 0 f 11 12 13 14 00010203
04 0 1 1 1 1 f000 f0 00010203 11 12 13 14 91 92 93 94 00100000 1 f 11 12 13 14 00010203
04 0 1 1 1 1 f000 f0 00010203 11 12 13 14 91 92 93 94 00010000 0 f 11 12 13 14 00010203
// flush while slot 1 of an mdu pair waits
05 0 1 1 4 4 0000 f0 00010203 11 12 13 14 91 92 93 94 00000010 1 f 11 12 13 14 00010203
05 1 1 1 4 4 0003 f0 00010203 11 12 13 14 91 92 93 94 00000000 1 f 11 12 13 14 00010203
05 0 1 1 4 4 0000 f0 00010203 11 12 13 14 91 92 93 94 00000010 1 f 11 12 13 14 00010203
05 0 1 1 4 4 0000 f0 00010203 11 12 13 14 91 92 93 94 00000001 0 f 11 12 13 14 00010203
// operand merge
06 0 0 0 0 0 0000 0f 040a1013 11 12 13 14 91 92 93 94 00000000 0 f 91 92 93 94 040a1013
06 0 0 0 0 0 0000 a5 00010203 11 12 13 14 91 92 93 94 00000000 0 f 11 92 13 94 00010203
06 0 0 0 0 0 0000 00 1f000a05 11 12 13 14 91 92 93 94 00000000 0 0 91 92 93 94 1f000a05
06 0 0 0 0 0 0000 c9 00010203 c000 c001 c002 c003 b000 b001 b002 b003 00000000 0 d c000 c001 b002 b003 00010203
06 0 0 0 0 0 0000 ff 00010203 deadbeef 0 1 7ff 5a5a 5a5a 5a5a 5a5a 00000000 0 f deadbeef 0 1 7ff 00010203

//--- sim.f
dispatch_pkg.sv
slot_classify.sv
station_alloc.sv
operand_merge.sv
dispatch_top.sv
dispatch_chk.sv
tb_dispatch.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_dispatch
FLIST     := sim.f
SIM_ARGS  := +verilator+error+limit+100

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
